// ==== build.f ====
+incdir+.
dts_pkg.sv
dts_frame_if.sv
dts_frame_align.sv
dts_offsetter.sv
dts_build_samples.sv
dts_gty_rx.sv
tb_dts_gty_rx.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_dts_gty_rx
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_dts_gty_rx.sv ====
`timescale 1ns/1ps
`include "dts_settings.svh"

module tb_dts_gty_rx;

  localparam int CLK_PERIOD   = 40;
  localparam int GUARD        = `DTS_BITSLIP_GUARD;
  localparam int BAD_WORDS    = 40;
  localparam int FRAME_CYCLES = `DTS_LOCK_COUNT + 3 + GUARD; // Lock, frame, two bad, drain
  localparam int OFFSET_STEPS = 14;
  localparam int RUN_CYCLES   = 5 + BAD_WORDS + GUARD + 1 + FRAME_CYCLES * (10 + OFFSET_STEPS)
                                + (GUARD + 1) * OFFSET_STEPS;

  localparam logic [159:0] IDLE_WORD = {`DTS_SYNC_WORD, 144'h0};
  localparam logic [159:0] BAD_WORD  = {~`DTS_SYNC_WORD, 144'h0};

  logic         gt_clkout;
  logic         rst_n_i;
  logic [159:0] gt_dout_i;
  logic         sample_mode_i;
  logic         shift_delay_i;
  logic         shift_advance_i;
  logic         shift_rst_i;
  logic         bitslip_o;
  logic         locked_o;
  logic [255:0] samples_o;
  logic         samples_vld_o;
  logic         index_o;
  logic         one_sec_o;
  logic         ten_sec_o;
  logic         sync_o;

  integer seed = 32'h3689;
  int     exp_offset; // Expected offsetter tap
  string  test_name;

  dts_gty_rx dts_gty_rx_i (.*);

  initial begin
    gt_clkout = 1'b0;
    forever #(CLK_PERIOD / 2) gt_clkout = ~gt_clkout;
  end

  initial begin
    #((RUN_CYCLES + 100) * CLK_PERIOD);
    $display("test failed");
    $fatal(1, "Timeout: tests did not finish within %0d cycles", RUN_CYCLES + 100);
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input string what, input logic [255:0] exp, input logic [255:0] act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      $display("test failed");
      $fatal(1, "Value mismatch on %s", what);
    end
  endtask

  function automatic logic [127:0] random_payload();
    logic [127:0] p;
    for (int i = 0; i < 4; i++) begin
      p[32*i +: 32] = $random(seed);
    end
    return p;
  endfunction

  // Nonzero reserved bits that the lane must drop
  function automatic logic [159:0] make_word(input logic [3:0] flags, input logic [127:0] payload);
    return {`DTS_SYNC_WORD, flags, 12'hABC, payload};
  endfunction

  function automatic logic [255:0] expected_samples(input logic [127:0] payload,
                                                    input logic three_bit);
    logic [255:0] s;
    int c;
    int v;
    s = '0;
    for (int n = 0; n < (three_bit ? 42 : 64); n++) begin
      c = three_bit ? int'(payload[3*n +: 3]) : int'(payload[2*n +: 2]);
      v = three_bit ? 2 * c - 7 : 2 * c - 3;
      s[4*n +: 4] = v[3:0];
    end
    return s;
  endfunction

  task automatic drive_word(input logic [159:0] w);
    @(negedge gt_clkout);
    gt_dout_i = w;
  endtask

  // Lock, one frame, a bad word while locked, then a slip whose guard drains the pipe
  task automatic send_frame(input logic [3:0] flags, input logic [127:0] payload);
    int           vld_cnt;
    int           lat;
    logic [255:0] got_samples;
    logic [3:0]   got_flags;
    vld_cnt     = 0;
    lat         = -1;
    got_samples = '0;
    got_flags   = '0;
    repeat (`DTS_LOCK_COUNT) drive_word(IDLE_WORD);
    drive_word(make_word(flags, payload));
    for (int k = 1; k <= 2 + GUARD; k++) begin
      @(negedge gt_clkout);
      if (samples_vld_o) begin
        vld_cnt++;
        lat         = k - 1; // Edges after the word was sampled
        got_samples = samples_o;
        got_flags   = {sync_o, ten_sec_o, one_sec_o, index_o};
      end
      if (k == 1) check_value("locked", 256'(1), 256'(locked_o));
      if (k == 3) begin
        check_value("lock drop", '0, 256'(locked_o));
        check_value("slip on lock drop", '0, 256'(bitslip_o));
      end
      if (k == 4) check_value("slip when unlocked", 256'(1), 256'(bitslip_o));
      gt_dout_i = (k <= 2) ? BAD_WORD : IDLE_WORD;
    end
    check_value("frame count", 256'(1), 256'(vld_cnt));
    check_value("latency", 256'(exp_offset + 3), 256'(lat));
    check_value("samples", expected_samples(payload, sample_mode_i), got_samples);
    check_value("flags", 256'(flags), 256'(got_flags));
  endtask

  // Pulse lands inside a guard window while no frame is in flight
  task automatic pulse_offset(input logic dly, input logic adv, input logic rst);
    @(negedge gt_clkout);
    gt_dout_i       = BAD_WORD;
    shift_delay_i   = dly;
    shift_advance_i = adv;
    shift_rst_i     = rst;
    @(negedge gt_clkout);
    gt_dout_i       = IDLE_WORD;
    shift_delay_i   = 1'b0;
    shift_advance_i = 1'b0;
    shift_rst_i     = 1'b0;
    repeat (GUARD - 1) drive_word(IDLE_WORD);
    if (rst) exp_offset = `DTS_OFFSET_DEFAULT;
    else if (dly && !adv && exp_offset < `DTS_OFFSET_DEPTH - 1) exp_offset++;
    else if (adv && !dly && exp_offset > 0) exp_offset--;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_bitslip();
    int slips;
    int fill;
    test_name = "bitslip";
    slips     = 0;
    // Idle words until the last guard window closes
    fill = ((BAD_WORDS - 1) / (GUARD + 1)) * (GUARD + 1) + GUARD + 1 - BAD_WORDS;
    for (int i = 0; i < BAD_WORDS + fill; i++) begin
      @(negedge gt_clkout);
      if (bitslip_o) slips++;
      check_value("locked", '0, 256'(locked_o));
      gt_dout_i = (i < BAD_WORDS) ? BAD_WORD : IDLE_WORD;
    end
    check_value("slip count", 256'((BAD_WORDS + GUARD) / (GUARD + 1)), 256'(slips));
  endtask

  task automatic test_lock_two_bit();
    test_name     = "lock_two_bit";
    sample_mode_i = 1'b0;
    send_frame(4'h0, random_payload());
  endtask

  task automatic test_three_bit();
    test_name     = "three_bit";
    sample_mode_i = 1'b1;
    repeat (3) send_frame(4'h0, random_payload());
    sample_mode_i = 1'b0;
  endtask

  task automatic test_flags();
    test_name = "flags";
    for (int i = 0; i < 4; i++) begin
      send_frame(4'(1 << i), random_payload()); // index, one_sec, ten_sec, sync
    end
  endtask

  task automatic test_offset();
    test_name = "offset";
    // Down past zero, up past the top, back one, opposite pulses, then shift reset
    for (int i = 0; i < OFFSET_STEPS; i++) begin
      pulse_offset((i >= 3 && i < 11) || i == 12, i < 3 || i == 11 || i == 12, i == 13);
      send_frame(4'h0, random_payload());
    end
  endtask

  task automatic test_lock_loss();
    test_name = "lock_loss";
    send_frame(4'hF, random_payload());
    send_frame(4'h5, random_payload()); // Relock after the drop
  endtask

  initial begin
    rst_n_i         = 1'b0;
    gt_dout_i       = IDLE_WORD;
    sample_mode_i   = 1'b0;
    shift_delay_i   = 1'b0;
    shift_advance_i = 1'b0;
    shift_rst_i     = 1'b0;
    exp_offset      = `DTS_OFFSET_DEFAULT;
    test_name       = "reset";
    repeat (5) @(posedge gt_clkout);
    @(negedge gt_clkout);
    check_value("outputs", '0, 256'({bitslip_o, locked_o, samples_vld_o,
                                     sync_o, ten_sec_o, one_sec_o, index_o}));
    rst_n_i = 1'b1;
    test_bitslip();
    test_lock_two_bit();
    test_three_bit();
    test_flags();
    test_offset();
    test_lock_loss();
    $display("test passed");
    $finish;
  end

endmodule

// ==== dts_gty_rx.sv ====
`timescale 1ns/1ps

module dts_gty_rx (
  input  logic         gt_clkout,
  input  logic         rst_n_i,
  input  logic [159:0] gt_dout_i,
  input  logic         sample_mode_i,   // 0 two-bit, 1 three-bit
  input  logic         shift_delay_i,
  input  logic         shift_advance_i,
  input  logic         shift_rst_i,
  output logic         bitslip_o,       // To transceiver gearbox
  output logic         locked_o,
  output logic [255:0] samples_o,       // 64 signed 4-bit samples
  output logic         samples_vld_o,
  output logic         index_o,
  output logic         one_sec_o,
  output logic         ten_sec_o,
  output logic         sync_o
);

  dts_frame_if align_to_buf ();
  dts_frame_if buf_to_samples ();

  dts_frame_align dts_frame_align_i (
    .gt_clkout (gt_clkout),
    .rst_n_i   (rst_n_i),
    .gt_dout_i (gt_dout_i),
    .bitslip_o (bitslip_o),
    .locked_o  (locked_o),
    .frame_o   (align_to_buf.source)
  );

  // Lane time alignment
  dts_offsetter dts_offsetter_i (
    .gt_clkout   (gt_clkout),
    .rst_n_i     (rst_n_i),
    .delay_i     (shift_delay_i),
    .advance_i   (shift_advance_i),
    .shift_rst_i (shift_rst_i),
    .frame_i     (align_to_buf.sink),
    .frame_o     (buf_to_samples.source)
  );

  dts_build_samples dts_build_samples_i (
    .gt_clkout     (gt_clkout),
    .rst_n_i       (rst_n_i),
    .mode_i        (dts_pkg::sample_mode_e'(sample_mode_i)),
    .frame_i       (buf_to_samples.sink),
    .samples_o     (samples_o),
    .samples_vld_o (samples_vld_o),
    .index_o       (index_o),
    .one_sec_o     (one_sec_o),
    .ten_sec_o     (ten_sec_o),
    .sync_o        (sync_o)
  );

endmodule

// ==== dts_build_samples.sv ====
`timescale 1ns/1ps

module dts_build_samples (
  input  logic                  gt_clkout,
  input  logic                  rst_n_i,
  input  dts_pkg::sample_mode_e mode_i,
  dts_frame_if.sink             frame_i,
  output logic [255:0]          samples_o,
  output logic                  samples_vld_o,
  output logic                  index_o,
  output logic                  one_sec_o,
  output logic                  ten_sec_o,
  output logic                  sync_o
);

  logic [255:0] samples_d;

  // Code c maps to 2c - 3, wraps into 4-bit two's complement
  function automatic logic [3:0] map_two(input logic [1:0] c);
    return {1'b0, c, 1'b0} - 4'd3;
  endfunction

  // Code c maps to 2c - 7
  function automatic logic [3:0] map_three(input logic [2:0] c);
    return {c, 1'b0} - 4'd7;
  endfunction

  always_comb begin
    samples_d = '0;
    if (mode_i == dts_pkg::MODE_TWO_BIT) begin
      for (int n = 0; n < 64; n++) begin
        samples_d[4*n +: 4] = map_two(frame_i.frame.payload[2*n +: 2]);
      end
    end else begin
      // Only 126 payload bits used, samples 42..63 stay zero
      for (int n = 0; n < 42; n++) begin
        samples_d[4*n +: 4] = map_three(frame_i.frame.payload[3*n +: 3]);
      end
    end
  end

  always_ff @(posedge gt_clkout) begin
    samples_o <= samples_d;
  end

  // Flags only pass with a valid frame
  always_ff @(posedge gt_clkout) begin
    if (!rst_n_i) begin
      samples_vld_o <= 1'b0;
      index_o       <= 1'b0;
      one_sec_o     <= 1'b0;
      ten_sec_o     <= 1'b0;
      sync_o        <= 1'b0;
    end else begin
      samples_vld_o <= frame_i.valid;
      index_o       <= frame_i.valid & frame_i.frame.index;
      one_sec_o     <= frame_i.valid & frame_i.frame.one_sec;
      ten_sec_o     <= frame_i.valid & frame_i.frame.ten_sec;
      sync_o        <= frame_i.valid & frame_i.frame.sync;
    end
  end

endmodule

// ==== dts_offsetter.sv ====
`timescale 1ns/1ps
`include "dts_settings.svh"

module dts_offsetter (
  input  logic        gt_clkout,
  input  logic        rst_n_i,
  input  logic        delay_i,
  input  logic        advance_i,
  input  logic        shift_rst_i,
  dts_frame_if.sink   frame_i,
  dts_frame_if.source frame_o
);

  localparam int DEPTH = `DTS_OFFSET_DEPTH;
  localparam int OFS_W = $clog2(DEPTH);

  localparam logic [OFS_W-1:0] OFS_MAX = OFS_W'(DEPTH - 1);
  localparam logic [OFS_W-1:0] OFS_DEF = OFS_W'(`DTS_OFFSET_DEFAULT);

  dts_pkg::dts_frame_t stage_q [DEPTH];
  logic [DEPTH-1:0]    vld_q;
  logic [OFS_W-1:0]    offset_q;

  ////////////////////
  // Delay line
  ////////////////////

  always_ff @(posedge gt_clkout) begin
    stage_q[0] <= frame_i.frame;
    for (int i = 1; i < DEPTH; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  always_ff @(posedge gt_clkout) begin
    if (!rst_n_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[DEPTH-2:0], frame_i.valid};
    end
  end

  ////////////////////
  // Tap control
  ////////////////////

  // Opposite pulses in one cycle cancel out
  always_ff @(posedge gt_clkout) begin
    if (!rst_n_i) begin
      offset_q <= OFS_DEF;
    end else if (shift_rst_i) begin
      offset_q <= OFS_DEF;
    end else if (delay_i && !advance_i) begin
      if (offset_q != OFS_MAX) begin
        offset_q <= offset_q + 1'b1;
      end
    end else if (advance_i && !delay_i) begin
      if (offset_q != '0) begin
        offset_q <= offset_q - 1'b1;
      end
    end
  end

  // Moving the tap repeats or skips frames
  assign frame_o.valid = vld_q[offset_q];
  assign frame_o.frame = stage_q[offset_q];

endmodule

// ==== dts_frame_align.sv ====
`timescale 1ns/1ps
`include "dts_settings.svh"

module dts_frame_align (
  input  logic                gt_clkout,
  input  logic                rst_n_i,
  input  logic [159:0]        gt_dout_i,
  output logic                bitslip_o,
  output logic                locked_o,
  dts_frame_if.source         frame_o
);

  localparam int CNT_W   = $clog2(`DTS_LOCK_COUNT + 1);
  localparam int GUARD_W = $clog2(`DTS_BITSLIP_GUARD + 1);

  logic [dts_pkg::SYNC_W-1:0]    sync_q;
  logic [dts_pkg::FLAG_W-1:0]    flags_q;
  logic [dts_pkg::PAYLOAD_W-1:0] payload_q;

  logic               hdr_good;
  logic               locked_q;
  logic [CNT_W-1:0]   good_cnt_q;
  logic [GUARD_W-1:0] guard_q;
  logic               bitslip_q;

  ////////////////////
  // Input word split
  ////////////////////

  // Reserved bits 139:128 are dropped here
  always_ff @(posedge gt_clkout) begin
    sync_q    <= gt_dout_i[dts_pkg::SYNC_LSB +: dts_pkg::SYNC_W];
    flags_q   <= gt_dout_i[dts_pkg::FLAG_LSB +: dts_pkg::FLAG_W];
    payload_q <= gt_dout_i[dts_pkg::PAYLOAD_W-1:0];
  end

  assign hdr_good = (sync_q == `DTS_SYNC_WORD);

  ////////////////////
  // Lock FSM
  ////////////////////

  always_ff @(posedge gt_clkout) begin
    if (!rst_n_i) begin
      locked_q      <= 1'b0;
      good_cnt_q    <= '0;
      guard_q       <= '0;
      bitslip_q     <= 1'b0;
      frame_o.valid <= 1'b0;
    end else begin
      bitslip_q     <= 1'b0; // Single-cycle request
      frame_o.valid <= 1'b0;

      if (guard_q != '0) begin
        // Transceiver still settling after a slip
        guard_q    <= guard_q - 1'b1;
        good_cnt_q <= '0;
      end else if (locked_q) begin
        if (hdr_good) begin
          frame_o.valid <= 1'b1;
        end else begin
          // Drop lock, no slip for this word
          locked_q   <= 1'b0;
          good_cnt_q <= '0;
        end
      end else if (hdr_good) begin
        good_cnt_q <= good_cnt_q + 1'b1;
        if (good_cnt_q == CNT_W'(`DTS_LOCK_COUNT - 1)) begin
          locked_q <= 1'b1;
        end
      end else begin
        // Header missing, shift the gearbox by one bit
        good_cnt_q <= '0;
        bitslip_q  <= 1'b1;
        guard_q    <= GUARD_W'(`DTS_BITSLIP_GUARD);
      end
    end
  end

  ////////////////////
  // Frame fields
  ////////////////////

  // Flag order in the word matches the struct, so a plain concat works
  always_ff @(posedge gt_clkout) begin
    frame_o.frame <= {flags_q, payload_q};
  end

  assign bitslip_o = bitslip_q;
  assign locked_o  = locked_q;

endmodule

// ==== dts_frame_if.sv ====
`timescale 1ns/1ps

// Frame strobe between lane blocks, no back-pressure
interface dts_frame_if;

  logic               valid;
  dts_pkg::dts_frame_t frame; // Only meaningful while valid

  modport source (
    output valid,
    output frame
  );

  modport sink (
    input valid,
    input frame
  );

endinterface

// ==== dts_pkg.sv ====
package dts_pkg;

  ////////////////////
  // Word layout
  ////////////////////

  localparam int SYNC_W    = 16;
  localparam int SYNC_LSB  = 144; // Sync field is 159:144
  localparam int FLAG_W    = 4;
  localparam int FLAG_LSB  = 140; // sync, ten_sec, one_sec, index from 143 down
  localparam int PAYLOAD_W = 128; // 139:128 reserved

  // Flags sit above the payload in the same order as in the word
  typedef struct packed {
    logic                 sync;
    logic                 ten_sec;
    logic                 one_sec;
    logic                 index;
    logic [PAYLOAD_W-1:0] payload;
  } dts_frame_t;

  typedef enum logic {
    MODE_TWO_BIT   = 1'b0,
    MODE_THREE_BIT = 1'b1
  } sample_mode_e;

endpackage

// ==== dts_settings.svh ====
`ifndef DTS_SETTINGS_SVH
`define DTS_SETTINGS_SVH

////////////////////
// Frame alignment
////////////////////

// Expected value of word bits 159:144
`define DTS_SYNC_WORD 16'hA55A

// Consecutive good headers before lock
`define DTS_LOCK_COUNT 4

// Words ignored after each bitslip request
`define DTS_BITSLIP_GUARD 16

////////////////////
// Lane offsetter
////////////////////

`define DTS_OFFSET_DEPTH 8   // Delay line stages
`define DTS_OFFSET_DEFAULT 2 // Tap after reset or shift reset

`endif
